// File: sim.f
verilog/axi4_rd_pkg.sv
verilog/rr_arbiter.sv
verilog/ar_request_capture.sv
verilog/r_response_router.sv
verilog/decerr_slave.sv
verilog/axi4_read_interconnect.sv
tests/axi4_read_interconnect_assertions.sv
tests/tb_axi4_read_interconnect.sv

// File: tests/tb_axi4_read_interconnect.sv
module tb_axi4_read_interconnect;
	timeunit 1ns;
	timeprecision 1ps;
	import axi4_rd_pkg::*;

	localparam int N_RANDOM = 200;
	localparam int TIMEOUT  = 4000;

	// Every burst is INCR of 4-byte beats
	localparam logic [2:0] AR_SIZE  = 3'd2;
	localparam logic [1:0] AR_BURST = 2'b01;

	logic       clk, rstn;
	logic       ar_valid [N_MASTERS], ar_ready [N_MASTERS], r_valid [N_MASTERS];
	logic       r_ready [N_MASTERS], r_last [N_MASTERS];
	addr_t      ar_addr [N_MASTERS];
	id_t        ar_id [N_MASTERS], r_id [N_MASTERS];
	logic [7:0] ar_len [N_MASTERS];
	logic [2:0] ar_size [N_MASTERS];
	logic [1:0] ar_burst [N_MASTERS], r_resp [N_MASTERS];
	data_t      r_data [N_MASTERS];
	logic       sar_valid [N_SLAVES], sar_ready [N_SLAVES], sr_valid [N_SLAVES];
	logic       sr_ready [N_SLAVES], sr_last [N_SLAVES];
	addr_t      sar_addr [N_SLAVES];
	sid_t       sar_id [N_SLAVES], sr_id [N_SLAVES];
	logic [7:0] sar_len [N_SLAVES];
	logic [2:0] sar_size [N_SLAVES];
	logic [1:0] sar_burst [N_SLAVES], sr_resp [N_SLAVES];
	data_t      sr_data [N_SLAVES];

	// Open bursts per master, indexed by ARID = {sequence, target slave}
	addr_t      exp_addr [N_MASTERS][16];
	logic [7:0] exp_len [N_MASTERS][16];
	logic       exp_busy [N_MASTERS][16];
	logic [1:0] tx_seq [N_MASTERS][N_SLAVES+1], rx_seq [N_MASTERS][N_SLAVES+1];
	int         rx_beat [N_MASTERS];
	id_t        cur_id [N_MASTERS];
	int         slave_queued [N_SLAVES];
	int         seed = 32'h33fd;

	axi4_read_interconnect axi4_read_interconnect_i (
		.clk(clk), .rstn(rstn),
		.ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr), .ar_id_i(ar_id),
		.ar_len_i(ar_len), .ar_size_i(ar_size), .ar_burst_i(ar_burst),
		.r_valid_o(r_valid), .r_ready_i(r_ready), .r_id_o(r_id), .r_data_o(r_data),
		.r_resp_o(r_resp), .r_last_o(r_last),
		.sar_valid_o(sar_valid), .sar_ready_i(sar_ready), .sar_addr_o(sar_addr),
		.sar_id_o(sar_id), .sar_len_o(sar_len), .sar_size_o(sar_size), .sar_burst_o(sar_burst),
		.sr_valid_i(sr_valid), .sr_ready_o(sr_ready), .sr_id_i(sr_id), .sr_data_i(sr_data),
		.sr_resp_i(sr_resp), .sr_last_i(sr_last)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			fail_run("A DUT output did not match its expected value");
		end
	endtask

	// {RRESP, RDATA} of one beat, top data byte holds the slave index
	function automatic logic [33:0] expected_beat(input addr_t addr, input int beat);
		addr_t beat_addr;
		beat_addr = addr + 32'(4 * beat);
		if (addr <= 32'h0000_ffff) begin
			return {OKAY, 8'h00, beat_addr[23:0]};
		end else if (addr <= 32'h0001_ffff) begin
			return {OKAY, 8'h01, beat_addr[23:0]};
		end
		return {DECERR, 32'h0};
	endfunction

	// Index N_SLAVES gives an unmapped address
	function automatic addr_t random_addr(input int slv);
		addr_t r;
		r = $random(seed);
		if (slv == N_SLAVES) begin
			return 32'h0002_0000 + (r & 32'h0fff_fffc);
		end
		return {15'h0, 1'(slv), r[13:0], 2'b00};
	endfunction

	function automatic int open_bursts();
		int n;
		n = 0;
		for (int m = 0; m < N_MASTERS; m++) begin
			for (int i = 0; i < 16; i++) begin
				n += int'(exp_busy[m][i]);
			end
		end
		return n;
	endfunction

	function automatic int queued_slave_bursts();
		int n;
		n = 0;
		for (int s = 0; s < N_SLAVES; s++) begin
			n += slave_queued[s];
		end
		return n;
	endfunction

	task automatic issue_read(input int m, input int slv, input addr_t addr,
			input logic [7:0] len);
		id_t id;
		int  t;
		id = {tx_seq[m][slv], 2'(slv)};
		t = 0;
		@(posedge clk);
		// Wait until this ID has no burst open
		while (exp_busy[m][id]) begin
			t++;
			if (t > TIMEOUT) fail_run("Timed out waiting for a free read ID");
			@(posedge clk);
		end
		#10;
		exp_busy[m][id] = 1'b1;
		exp_addr[m][id] = addr;
		exp_len[m][id]  = len;
		tx_seq[m][slv]  = tx_seq[m][slv] + 1'b1;
		ar_valid[m] = 1'b1;
		ar_addr[m]  = addr;
		ar_id[m]    = id;
		ar_len[m]   = len;
		ar_size[m]  = AR_SIZE;
		ar_burst[m] = AR_BURST;
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT) fail_run("Timed out waiting for ARREADY");
		end while (!ar_ready[m]);
		#10;
		ar_valid[m] = 1'b0;
	endtask

	task automatic random_traffic(input int m, input int count);
		int slv;
		repeat (count) begin
			slv = $unsigned($random(seed)) % (N_SLAVES + 1);
			issue_read(m, slv, random_addr(slv), 8'($random(seed) & 7));
		end
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (open_bursts() != 0) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT) fail_run("Timed out waiting for read bursts to complete");
		end
	endtask

	task automatic check_beat(input int m);
		id_t         id;
		logic [1:0]  slv;
		logic [33:0] exp;
		if (rx_beat[m] == 0) begin
			id  = r_id[m];
			slv = id[1:0];
			if (!exp_busy[m][id]) begin
				fail_run($sformatf("Master %0d got a beat with unknown RID %h", m, id));
			end
			// Same slave returns bursts in issue order
			check_value($sformatf("RID[%0d]", m), id, {rx_seq[m][slv], slv});
			cur_id[m] = id;
		end else begin
			// Beats of one burst arrive back to back under the same RID
			id  = cur_id[m];
			slv = id[1:0];
			check_value($sformatf("RID[%0d]", m), r_id[m], id);
		end
		exp = expected_beat(exp_addr[m][id], rx_beat[m]);
		check_value($sformatf("RDATA[%0d]", m), r_data[m], exp[31:0]);
		check_value($sformatf("RRESP[%0d]", m), r_resp[m], exp[33:32]);
		check_value($sformatf("RLAST[%0d]", m), r_last[m], rx_beat[m] == int'(exp_len[m][id]));
		if (r_last[m]) begin
			exp_busy[m][id] = 1'b0;
			rx_seq[m][slv]  = rx_seq[m][slv] + 1'b1;
			rx_beat[m]      = 0;
		end else begin
			rx_beat[m]++;
		end
	endtask

	// Compare process, also drives random RREADY
	initial begin
		forever begin
			@(posedge clk);
			for (int m = 0; m < N_MASTERS; m++) begin
				if (rstn && r_valid[m] && r_ready[m]) check_beat(m);
			end
			#10;
			for (int m = 0; m < N_MASTERS; m++) r_ready[m] = ($random(seed) & 3) != 0;
		end
	end

	always @(posedge clk) begin
		if (axi4_read_interconnect_i.assertions_i.violation === 1'b1) begin
			fail_run("A bound protocol assertion failed");
		end
	end

	// Slave models, in order, random AR ready and gaps between beats
	for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave_model
		addr_t      addr_q [$];
		sid_t       id_q [$];
		logic [7:0] len_q [$];

		initial begin
			int   beat;
			logic taken;
			beat = 0;
			forever begin
				@(posedge clk);
				if (sar_valid[s] && sar_ready[s]) begin
					check_value($sformatf("SARSIZE[%0d]", s), sar_size[s], AR_SIZE);
					check_value($sformatf("SARBURST[%0d]", s), sar_burst[s], AR_BURST);
					addr_q.push_back(sar_addr[s]);
					id_q.push_back(sar_id[s]);
					len_q.push_back(sar_len[s]);
				end
				taken = sr_valid[s] && sr_ready[s];
				if (taken && sr_last[s]) begin
					addr_q.delete(0);
					id_q.delete(0);
					len_q.delete(0);
					beat = 0;
				end else if (taken) begin
					beat++;
				end
				slave_queued[s] = addr_q.size();
				#10;
				sar_ready[s] = ($random(seed) & 3) != 0;
				if (!sr_valid[s] || taken) begin
					sr_valid[s] = (addr_q.size() > 0) && (($random(seed) & 3) != 0);
					if (addr_q.size() > 0) begin
						sr_id[s]   = id_q[0];
						sr_data[s] = {8'(s), 24'(addr_q[0] + 32'(4 * beat))};
						sr_resp[s] = OKAY;
						sr_last[s] = (beat == int'(len_q[0]));
					end
				end
			end
		end
	end

	initial begin
		rstn = 1'b0;
		for (int m = 0; m < N_MASTERS; m++) begin
			ar_valid[m] = 1'b0;
			ar_addr[m]  = '0;
			ar_id[m]    = '0;
			ar_len[m]   = '0;
			ar_size[m]  = '0;
			ar_burst[m] = '0;
			r_ready[m]  = 1'b0;
			rx_beat[m]  = 0;
			cur_id[m]   = '0;
			for (int i = 0; i < 16; i++) exp_busy[m][i] = 1'b0;
			for (int s = 0; s <= N_SLAVES; s++) begin
				tx_seq[m][s] = '0;
				rx_seq[m][s] = '0;
			end
		end
		for (int s = 0; s < N_SLAVES; s++) begin
			sar_ready[s]    = 1'b0;
			sr_valid[s]     = 1'b0;
			sr_id[s]        = '0;
			sr_data[s]      = '0;
			sr_resp[s]      = '0;
			sr_last[s]      = 1'b0;
			slave_queued[s] = 0;
		end

		// Reset for 4 cycles, then one more cycle quiet
		for (int c = 0; c < 5; c++) begin
			if (c == 4) rstn = 1'b1;
			@(posedge clk);
			#1;
			for (int m = 0; m < N_MASTERS; m++) begin
				if (c < 4) check_value($sformatf("ARREADY[%0d]", m), ar_ready[m], 32'h0);
				check_value($sformatf("RVALID[%0d]", m), r_valid[m], 32'h0);
			end
			for (int s = 0; s < N_SLAVES; s++) begin
				check_value($sformatf("SARVALID[%0d]", s), sar_valid[s], 32'h0);
			end
			#9;
		end

		// Single bursts, every master to every slave and to unmapped space
		for (int m = 0; m < N_MASTERS; m++) begin
			for (int s = 0; s <= N_SLAVES; s++) begin
				for (int len = 0; len < 8; len++) begin
					issue_read(m, s, random_addr(s), 8'(len));
					drain();
				end
			end
		end

		// Both masters on the same slave at once
		for (int s = 0; s <= N_SLAVES; s++) begin
			fork
				issue_read(0, s, random_addr(s), 8'd3);
				issue_read(1, s, random_addr(s), 8'd5);
			join
			drain();
		end

		fork
			random_traffic(0, N_RANDOM / 2);
			random_traffic(1, N_RANDOM / 2);
		join
		drain();

		// Let the slave models retire the last beat
		@(posedge clk);
		#1;
		if (queued_slave_bursts() != 0) begin
			fail_run("A slave model still held read requests at the end of the test");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// File: tests/axi4_read_interconnect_assertions.sv
module axi4_read_interconnect_assertions (
	input logic               clk,
	input logic               rstn,
	input logic               ar_ready_i  [axi4_rd_pkg::N_MASTERS],
	input logic               r_valid_i   [axi4_rd_pkg::N_MASTERS],
	input logic               r_ready_i   [axi4_rd_pkg::N_MASTERS],
	input axi4_rd_pkg::id_t   r_id_i      [axi4_rd_pkg::N_MASTERS],
	input logic               r_last_i    [axi4_rd_pkg::N_MASTERS],
	input logic               sar_valid_i [axi4_rd_pkg::N_SLAVES],
	input logic               sar_ready_i [axi4_rd_pkg::N_SLAVES],
	input axi4_rd_pkg::addr_t sar_addr_i  [axi4_rd_pkg::N_SLAVES],
	input axi4_rd_pkg::sid_t  sar_id_i    [axi4_rd_pkg::N_SLAVES],
	input logic [7:0]         sar_len_i   [axi4_rd_pkg::N_SLAVES],
	input logic [2:0]         sar_size_i  [axi4_rd_pkg::N_SLAVES],
	input logic [1:0]         sar_burst_i [axi4_rd_pkg::N_SLAVES]
);
	timeunit 1ns;
	timeprecision 1ps;
	import axi4_rd_pkg::*;

	// Set by any failing property
	logic violation = 1'b0;

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
		// ARREADY is registered, so check from the second reset cycle on
		ar_ready_in_reset: assert property (@(posedge clk) (!rstn ##1 !rstn) |-> !ar_ready_i[m])
		else begin
			violation = 1'b1;
			$error("ARREADY high while rstn is low");
		end

		r_stable: assert property (@(posedge clk) disable iff (!rstn)
			r_valid_i[m] && !r_ready_i[m] |=>
			r_valid_i[m] && $stable(r_id_i[m]) && $stable(r_last_i[m]))
		else begin
			violation = 1'b1;
			$error("RVALID, RID or RLAST changed before RREADY");
		end
	end

	for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave
		sar_stable: assert property (@(posedge clk) disable iff (!rstn)
			sar_valid_i[s] && !sar_ready_i[s] |=>
			sar_valid_i[s] && $stable(sar_addr_i[s]) && $stable(sar_id_i[s])
			&& $stable(sar_len_i[s]) && $stable(sar_size_i[s]) && $stable(sar_burst_i[s]))
		else begin
			violation = 1'b1;
			$error("SARVALID or its payload changed before SARREADY");
		end
	end

endmodule

bind axi4_read_interconnect axi4_read_interconnect_assertions assertions_i (
	.clk(clk), .rstn(rstn), .ar_ready_i(ar_ready_o),
	.r_valid_i(r_valid_o), .r_ready_i(r_ready_i), .r_id_i(r_id_o), .r_last_i(r_last_o),
	.sar_valid_i(sar_valid_o), .sar_ready_i(sar_ready_i), .sar_addr_i(sar_addr_o),
	.sar_id_i(sar_id_o), .sar_len_i(sar_len_o), .sar_size_i(sar_size_o),
	.sar_burst_i(sar_burst_o)
);

// File: verilog/axi4_read_interconnect.sv
module axi4_read_interconnect (
	input  logic               clk,
	input  logic               rstn,
	input  logic               ar_valid_i  [axi4_rd_pkg::N_MASTERS],
	output logic               ar_ready_o  [axi4_rd_pkg::N_MASTERS],
	input  axi4_rd_pkg::addr_t ar_addr_i   [axi4_rd_pkg::N_MASTERS],
	input  axi4_rd_pkg::id_t   ar_id_i     [axi4_rd_pkg::N_MASTERS],
	input  logic [7:0]         ar_len_i    [axi4_rd_pkg::N_MASTERS],
	input  logic [2:0]         ar_size_i   [axi4_rd_pkg::N_MASTERS],
	input  logic [1:0]         ar_burst_i  [axi4_rd_pkg::N_MASTERS],
	output logic               r_valid_o   [axi4_rd_pkg::N_MASTERS],
	input  logic               r_ready_i   [axi4_rd_pkg::N_MASTERS],
	output axi4_rd_pkg::id_t   r_id_o      [axi4_rd_pkg::N_MASTERS],
	output axi4_rd_pkg::data_t r_data_o    [axi4_rd_pkg::N_MASTERS],
	output logic [1:0]         r_resp_o    [axi4_rd_pkg::N_MASTERS],
	output logic               r_last_o    [axi4_rd_pkg::N_MASTERS],
	output logic               sar_valid_o [axi4_rd_pkg::N_SLAVES],
	input  logic               sar_ready_i [axi4_rd_pkg::N_SLAVES],
	output axi4_rd_pkg::addr_t sar_addr_o  [axi4_rd_pkg::N_SLAVES],
	output axi4_rd_pkg::sid_t  sar_id_o    [axi4_rd_pkg::N_SLAVES],
	output logic [7:0]         sar_len_o   [axi4_rd_pkg::N_SLAVES],
	output logic [2:0]         sar_size_o  [axi4_rd_pkg::N_SLAVES],
	output logic [1:0]         sar_burst_o [axi4_rd_pkg::N_SLAVES],
	input  logic               sr_valid_i  [axi4_rd_pkg::N_SLAVES],
	output logic               sr_ready_o  [axi4_rd_pkg::N_SLAVES],
	input  axi4_rd_pkg::sid_t  sr_id_i     [axi4_rd_pkg::N_SLAVES],
	input  axi4_rd_pkg::data_t sr_data_i   [axi4_rd_pkg::N_SLAVES],
	input  logic [1:0]         sr_resp_i   [axi4_rd_pkg::N_SLAVES],
	input  logic               sr_last_i   [axi4_rd_pkg::N_SLAVES]
);
	import axi4_rd_pkg::*;

	// Capture stages, one per master
	slv_t       cap_sel       [N_MASTERS];
	logic       cap_req       [N_MASTERS];
	logic       cap_granted   [N_MASTERS];
	logic       cap_sar_ready [N_MASTERS];
	logic       cap_sar_valid [N_MASTERS];
	addr_t      cap_addr      [N_MASTERS];
	sid_t       cap_id        [N_MASTERS];
	logic [7:0] cap_len       [N_MASTERS];
	logic [2:0] cap_size      [N_MASTERS];
	logic [1:0] cap_burst     [N_MASTERS];

	// Slave side, the default slave sits at index N_SLAVES
	logic [N_MASTERS-1:0] ar_req       [N_SLAVES+1];
	logic                 ar_gnt       [N_SLAVES+1];
	mid_t                 ar_gnt_id    [N_SLAVES+1];
	logic                 slv_ar_valid [N_SLAVES+1];
	logic                 slv_ar_ready [N_SLAVES+1];
	sid_t                 slv_ar_id    [N_SLAVES+1];
	logic [7:0]           slv_ar_len   [N_SLAVES+1];
	logic                 slv_r_valid  [N_SLAVES+1];
	logic                 slv_r_ready  [N_SLAVES+1];
	sid_t                 slv_r_id     [N_SLAVES+1];
	data_t                slv_r_data   [N_SLAVES+1];
	logic [1:0]           slv_r_resp   [N_SLAVES+1];
	logic                 slv_r_last   [N_SLAVES+1];

	// Routers, one per slave
	mid_t       rt_target  [N_SLAVES+1];
	logic       rt_req     [N_SLAVES+1];
	logic       rt_granted [N_SLAVES+1];
	logic       rt_valid   [N_SLAVES+1];
	id_t        rt_id      [N_SLAVES+1];
	data_t      rt_data    [N_SLAVES+1];
	logic [1:0] rt_resp    [N_SLAVES+1];
	logic       rt_last    [N_SLAVES+1];

	// Read data arbitration, one arbiter per master
	logic [N_SLAVES:0] r_req    [N_MASTERS];
	logic              r_gnt    [N_MASTERS];
	slv_t              r_gnt_id [N_MASTERS];

	always_comb begin
		for (int s = 0; s <= N_SLAVES; s++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				ar_req[s][m] = cap_req[m] && (cap_sel[m] == slv_t'(s));
				r_req[m][s]  = rt_req[s] && (rt_target[s] == mid_t'(m));
			end
			rt_granted[s] = r_gnt[rt_target[s]] && (r_gnt_id[rt_target[s]] == slv_t'(s));
		end
		// Grant and ready seen by each capture stage come from its selected slave
		for (int m = 0; m < N_MASTERS; m++) begin
			cap_granted[m]   = 1'b0;
			cap_sar_ready[m] = 1'b0;
			for (int s = 0; s <= N_SLAVES; s++) begin
				if (cap_sel[m] == slv_t'(s)) begin
					cap_granted[m]   = ar_gnt[s] && (ar_gnt_id[s] == mid_t'(m));
					cap_sar_ready[m] = slv_ar_ready[s];
				end
			end
		end
	end

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
		ar_request_capture capture_i (
			.clk(clk), .rstn(rstn), .master_idx_i(mid_t'(m)),
			.ar_valid_i(ar_valid_i[m]), .ar_ready_o(ar_ready_o[m]),
			.ar_addr_i(ar_addr_i[m]), .ar_id_i(ar_id_i[m]), .ar_len_i(ar_len_i[m]),
			.ar_size_i(ar_size_i[m]), .ar_burst_i(ar_burst_i[m]),
			.sel_o(cap_sel[m]), .req_o(cap_req[m]), .granted_i(cap_granted[m]),
			.sar_ready_i(cap_sar_ready[m]), .sar_valid_o(cap_sar_valid[m]),
			.sar_addr_o(cap_addr[m]), .sar_id_o(cap_id[m]), .sar_len_o(cap_len[m]),
			.sar_size_o(cap_size[m]), .sar_burst_o(cap_burst[m])
		);

		rr_arbiter #(.N_REQ(N_SLAVES + 1)) r_arb_i (
			.clk(clk), .rstn(rstn), .req_i(r_req[m]),
			.gnt_o(r_gnt[m]), .gnt_id_o(r_gnt_id[m])
		);

		// Granted router drives this master
		assign r_valid_o[m] = r_gnt[m] && rt_valid[r_gnt_id[m]];
		assign r_id_o[m]    = rt_id[r_gnt_id[m]];
		assign r_data_o[m]  = rt_data[r_gnt_id[m]];
		assign r_resp_o[m]  = rt_resp[r_gnt_id[m]];
		assign r_last_o[m]  = rt_last[r_gnt_id[m]];
	end

	for (genvar s = 0; s <= N_SLAVES; s++) begin : g_slave
		rr_arbiter #(.N_REQ(N_MASTERS)) ar_arb_i (
			.clk(clk), .rstn(rstn), .req_i(ar_req[s]),
			.gnt_o(ar_gnt[s]), .gnt_id_o(ar_gnt_id[s])
		);

		r_response_router router_i (
			.clk(clk), .rstn(rstn),
			.sr_valid_i(slv_r_valid[s]), .sr_ready_o(slv_r_ready[s]), .sr_id_i(slv_r_id[s]),
			.sr_data_i(slv_r_data[s]), .sr_resp_i(slv_r_resp[s]), .sr_last_i(slv_r_last[s]),
			.target_o(rt_target[s]), .req_o(rt_req[s]), .granted_i(rt_granted[s]),
			.r_valid_o(rt_valid[s]), .r_ready_i(r_ready_i[rt_target[s]]), .r_id_o(rt_id[s]),
			.r_data_o(rt_data[s]), .r_resp_o(rt_resp[s]), .r_last_o(rt_last[s])
		);

		// Granted capture stage drives this slave
		assign slv_ar_valid[s] = ar_gnt[s] && cap_sar_valid[ar_gnt_id[s]];
		assign slv_ar_id[s]    = cap_id[ar_gnt_id[s]];
		assign slv_ar_len[s]   = cap_len[ar_gnt_id[s]];

		if (s < N_SLAVES) begin : g_ext
			assign sar_valid_o[s]  = slv_ar_valid[s];
			assign sar_id_o[s]     = slv_ar_id[s];
			assign sar_len_o[s]    = slv_ar_len[s];
			assign sar_addr_o[s]   = cap_addr[ar_gnt_id[s]];
			assign sar_size_o[s]   = cap_size[ar_gnt_id[s]];
			assign sar_burst_o[s]  = cap_burst[ar_gnt_id[s]];
			assign slv_ar_ready[s] = sar_ready_i[s];
			assign slv_r_valid[s]  = sr_valid_i[s];
			assign slv_r_id[s]     = sr_id_i[s];
			assign slv_r_data[s]   = sr_data_i[s];
			assign slv_r_resp[s]   = sr_resp_i[s];
			assign slv_r_last[s]   = sr_last_i[s];
			assign sr_ready_o[s]   = slv_r_ready[s];
		end
	end

	// Unmapped reads end here
	decerr_slave decerr_slave_i (
		.clk(clk), .rstn(rstn),
		.ar_valid_i(slv_ar_valid[N_SLAVES]), .ar_ready_o(slv_ar_ready[N_SLAVES]),
		.ar_id_i(slv_ar_id[N_SLAVES]), .ar_len_i(slv_ar_len[N_SLAVES]),
		.r_valid_o(slv_r_valid[N_SLAVES]), .r_ready_i(slv_r_ready[N_SLAVES]),
		.r_id_o(slv_r_id[N_SLAVES]), .r_data_o(slv_r_data[N_SLAVES]),
		.r_resp_o(slv_r_resp[N_SLAVES]), .r_last_o(slv_r_last[N_SLAVES])
	);

endmodule

// File: verilog/decerr_slave.sv
module decerr_slave (
	input  logic               clk,
	input  logic               rstn,
	input  logic               ar_valid_i,
	output logic               ar_ready_o,
	input  axi4_rd_pkg::sid_t  ar_id_i,
	input  logic [7:0]         ar_len_i,
	output logic               r_valid_o,
	input  logic               r_ready_i,
	output axi4_rd_pkg::sid_t  r_id_o,
	output axi4_rd_pkg::data_t r_data_o,
	output logic [1:0]         r_resp_o,
	output logic               r_last_o
);
	import axi4_rd_pkg::*;

	logic       busy;
	logic [7:0] beat_cnt;
	logic [7:0] len_q;

	assign r_valid_o = busy;
	assign r_last_o  = busy && (beat_cnt == len_q);
	assign r_data_o  = '0;
	assign r_resp_o  = DECERR;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy       <= 1'b0;
			ar_ready_o <= 1'b0;
			beat_cnt   <= '0;
		end else if (!busy) begin
			if (ar_valid_i && ar_ready_o) begin
				ar_ready_o <= 1'b0;
				busy       <= 1'b1;
				beat_cnt   <= '0;
			end else begin
				// Ready follows valid by one cycle
				ar_ready_o <= ar_valid_i;
			end
		end else if (r_ready_i) begin
			if (r_last_o) begin
				busy <= 1'b0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && ar_valid_i && ar_ready_o) begin
			r_id_o <= ar_id_i;
			len_q  <= ar_len_i;
		end
	end

endmodule

// File: verilog/r_response_router.sv
module r_response_router (
	input  logic               clk,
	input  logic               rstn,
	input  logic               sr_valid_i,
	output logic               sr_ready_o,
	input  axi4_rd_pkg::sid_t  sr_id_i,
	input  axi4_rd_pkg::data_t sr_data_i,
	input  logic [1:0]         sr_resp_i,
	input  logic               sr_last_i,
	output axi4_rd_pkg::mid_t  target_o,
	output logic               req_o,
	input  logic               granted_i,
	output logic               r_valid_o,
	input  logic               r_ready_i,
	output axi4_rd_pkg::id_t   r_id_o,
	output axi4_rd_pkg::data_t r_data_o,
	output logic [1:0]         r_resp_o,
	output logic               r_last_o
);
	import axi4_rd_pkg::*;

	route_state_e state;
	logic         streaming;

	assign streaming = (state == RT_STREAM);

	// Hold the request for the whole burst so the grant stays put
	assign req_o = (state != RT_IDLE);

	// Valid and ready only meet while streaming
	assign r_valid_o  = streaming && sr_valid_i;
	assign sr_ready_o = streaming && r_ready_i;

	// Master tag removed on the way back
	assign r_id_o   = sr_id_i[ID_W-1:0];
	assign r_data_o = sr_data_i;
	assign r_resp_o = sr_resp_i;
	assign r_last_o = sr_last_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= RT_IDLE;
		end else begin
			case (state)
				RT_IDLE: begin
					if (sr_valid_i) begin
						state <= RT_WAIT_GNT;
					end
				end
				RT_WAIT_GNT: begin
					if (granted_i) begin
						state <= RT_STREAM;
					end
				end
				RT_STREAM: begin
					if (sr_valid_i && sr_ready_o && sr_last_i) begin
						state <= RT_IDLE;
					end
				end
				default: state <= RT_IDLE;
			endcase
		end
	end

	// Target master taken from the tag of the first beat
	always_ff @(posedge clk) begin
		if (state == RT_IDLE && sr_valid_i) begin
			target_o <= sr_id_i[ID_W +: MID_W];
		end
	end

endmodule

// File: verilog/ar_request_capture.sv
module ar_request_capture (
	input  logic               clk,
	input  logic               rstn,
	input  axi4_rd_pkg::mid_t  master_idx_i,
	input  logic               ar_valid_i,
	output logic               ar_ready_o,
	input  axi4_rd_pkg::addr_t ar_addr_i,
	input  axi4_rd_pkg::id_t   ar_id_i,
	input  logic [7:0]         ar_len_i,
	input  logic [2:0]         ar_size_i,
	input  logic [1:0]         ar_burst_i,
	output axi4_rd_pkg::slv_t  sel_o,
	output logic               req_o,
	input  logic               granted_i,
	input  logic               sar_ready_i,
	output logic               sar_valid_o,
	output axi4_rd_pkg::addr_t sar_addr_o,
	output axi4_rd_pkg::sid_t  sar_id_o,
	output logic [7:0]         sar_len_o,
	output logic [2:0]         sar_size_o,
	output logic [1:0]         sar_burst_o
);
	import axi4_rd_pkg::*;

	cap_state_e state;
	slv_t       dec_sel;

	// Address map lookup, a miss goes to the default slave
	always_comb begin
		dec_sel = slv_t'(N_SLAVES);
		for (int s = 0; s < N_SLAVES; s++) begin
			if (sar_addr_o >= SLAVE_BASE[s] && sar_addr_o <= SLAVE_LIMIT[s]) begin
				dec_sel = slv_t'(s);
			end
		end
	end

	assign req_o       = (state == CAP_REQUEST);
	assign sar_valid_o = (state == CAP_REQUEST);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state      <= CAP_IDLE;
			ar_ready_o <= 1'b0;
			sel_o      <= SID_NONE;
		end else begin
			case (state)
				CAP_IDLE: begin
					ar_ready_o <= 1'b1;
					if (ar_valid_i && ar_ready_o) begin
						ar_ready_o <= 1'b0;
						state      <= CAP_DECODE;
					end
				end
				CAP_DECODE: begin
					sel_o <= dec_sel;
					state <= CAP_REQUEST;
				end
				CAP_REQUEST: begin
					// Leave once the selected slave takes the request
					if (granted_i && sar_ready_i) begin
						sel_o      <= SID_NONE;
						ar_ready_o <= 1'b1;
						state      <= CAP_IDLE;
					end
				end
				default: state <= CAP_IDLE;
			endcase
		end
	end

	// Request fields, master index goes into the upper ID bits
	always_ff @(posedge clk) begin
		if (ar_valid_i && ar_ready_o) begin
			sar_addr_o  <= ar_addr_i;
			sar_id_o    <= {master_idx_i, ar_id_i};
			sar_len_o   <= ar_len_i;
			sar_size_o  <= ar_size_i;
			sar_burst_o <= ar_burst_i;
		end
	end

endmodule

// File: verilog/rr_arbiter.sv
module rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);

	logic [N_REQ-1:0]         last_gnt;
	logic [N_REQ-1:0]         above_last;
	logic [N_REQ-1:0]         masked_pri;
	logic [N_REQ-1:0]         unmasked_pri;
	logic [N_REQ-1:0]         win_vec;
	logic [$clog2(N_REQ)-1:0] win_id;

	// Positions strictly above the last winner
	always_comb begin
		above_last[0] = 1'b0;
		for (int i = 1; i < N_REQ; i++) begin
			above_last[i] = above_last[i-1] | last_gnt[i-1];
		end
	end

	// Lowest set bit of each candidate vector
	assign masked_pri   = (req_i & above_last) & (~(req_i & above_last) + 1'b1);
	assign unmasked_pri = req_i & (~req_i + 1'b1);
	assign win_vec      = (|masked_pri) ? masked_pri : unmasked_pri;

	always_comb begin
		win_id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (win_vec[i]) begin
				win_id = ($clog2(N_REQ))'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			gnt_id_o <= '0;
			last_gnt <= '0;
		end else if (!gnt_o) begin
			if (|req_i) begin
				gnt_o    <= 1'b1;
				gnt_id_o <= win_id;
				last_gnt <= win_vec;
			end
		end else if (!req_i[gnt_id_o]) begin
			// Owner released, back to idle for one cycle
			gnt_o <= 1'b0;
		end
	end

endmodule

// File: verilog/axi4_rd_pkg.sv
package axi4_rd_pkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int ID_W      = 4;
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES  = 2;
	localparam int MID_W     = 1;
	localparam int SID_W     = 2;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [ID_W-1:0]       id_t;
	typedef logic [ID_W+MID_W-1:0] sid_t;
	typedef logic [MID_W-1:0]      mid_t;
	typedef logic [SID_W-1:0]      slv_t;

	// No slave selected
	localparam slv_t SID_NONE = '1;

	// Inclusive address window of each external slave
	localparam addr_t SLAVE_BASE [N_SLAVES]  = '{32'h0000_0000, 32'h0001_0000};
	localparam addr_t SLAVE_LIMIT [N_SLAVES] = '{32'h0000_ffff, 32'h0001_ffff};

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	typedef enum logic [1:0] {CAP_IDLE, CAP_DECODE, CAP_REQUEST} cap_state_e;

	typedef enum logic [1:0] {RT_IDLE, RT_WAIT_GNT, RT_STREAM} route_state_e;

endpackage
